// File: pipe16.f
source/pipe16_pkg.sv
source/pipe16_rf_if.sv
source/pipe16_stage_reg.sv
source/pipe16_fetch.sv
source/pipe16_control.sv
source/pipe16_regfile.sv
source/pipe16_alu.sv
source/pipe16_hazard.sv
source/pipe16_lsu.sv
source/pipe16_proc.sv
sim/tb_pipe16_mem.sv
sim/tb_pipe16.sv

// File: sim/tb_pipe16.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipe16
   import pipe16_pkg::*;
();

   // all runs together stay below 2000 cycles
   localparam int MAX_CYCLES = 4000;
   localparam int POST_HALT  = 16;

   logic        clk;
   logic        rst_n;
   logic        rand_ack;
   logic [15:0] iaddr;
   logic [15:0] inst;
   logic        cyc;
   logic        stb;
   logic        we;
   logic [15:0] adr;
   logic [15:0] dat_w;
   logic [15:0] dat_r;
   logic        ack;
   logic        err;
   logic        halt;
   int          cycles = 0;
   logic [15:0] prog [$];
   logic [15:0] snap [256];

   pipe16_proc UUT (
      .clk     (clk),
      .rst_n   (rst_n),
      .iaddr_o (iaddr),
      .inst_i  (inst),
      .cyc_o   (cyc),
      .stb_o   (stb),
      .we_o    (we),
      .adr_o   (adr),
      .dat_o   (dat_w),
      .dat_i   (dat_r),
      .ack_i   (ack),
      .err_o   (err),
      .halt_o  (halt)
   );

   tb_pipe16_mem u_mem (
      .clk        (clk),
      .rst_n      (rst_n),
      .rand_ack_i (rand_ack),
      .iaddr_i    (iaddr),
      .inst_o     (inst),
      .cyc_i      (cyc),
      .stb_i      (stb),
      .we_i       (we),
      .adr_i      (adr),
      .dat_i      (dat_w),
      .dat_o      (dat_r),
      .ack_o      (ack)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the processor did not finish within %0d cycles", MAX_CYCLES);
         $display("Test failures found");
         $fatal(1, "simulation timeout");
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_equal(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         $display("Test failures found");
         $fatal(1, "check failed");
      end
   endtask

   function automatic logic [15:0] rr_inst(opcode_e op, int rd, int rs, int rt);
      return {op, 3'(rs), 3'(rt), 3'(rd), 2'b00};
   endfunction

   function automatic logic [15:0] imm_inst(opcode_e op, int rt, int rs, int imm);
      return {op, 3'(rs), 3'(rt), 5'(imm)};
   endfunction

   function automatic logic [15:0] branch_inst(opcode_e op, int rs, int off);
      return {op, 3'(rs), 8'(off)};
   endfunction

   function automatic logic [15:0] jump_inst(int off);
      return {OP_J, 11'(off)};
   endfunction

   // preload pattern, every address bit shows up in the word
   function automatic logic [15:0] fill_word(int a);
      return {~8'(a), 8'(a)};
   endfunction

   task automatic load_program();
      for (int i = 0; i < 256; i++) begin
         u_mem.rom[i] = (i < prog.size()) ? prog[i] : NOP_INST;
         u_mem.ram[i] = fill_word(i);
      end
   endtask

   // reset, run to HALT, then watch the quiet pipeline for a while
   task automatic run_program(input logic rnd, input logic exp_err);
      int writes;
      load_program();
      @(posedge clk);
      rst_n    <= 1'b0;
      rand_ack <= rnd;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      while (halt !== 1'b1) begin
         // classic single transfers, strobe and cycle move together
         check_equal("stb_o matches cyc_o", stb, cyc);
         @(negedge clk);
      end
      writes = u_mem.n_writes;
      repeat (POST_HALT) begin
         @(negedge clk);
         check_equal("halt_o held after HALT", halt, 1'b1);
         check_equal("bus idle after HALT", cyc, 1'b0);
         check_equal("strobe idle after HALT", stb, 1'b0);
         check_equal("err_o after HALT", err, exp_err);
      end
      check_equal("store count after HALT", 16'(u_mem.n_writes), 16'(writes));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // programs
   ////////////////////////////////////////////////////////////////////////////

   // back-to-back dependencies, stores from r7 down to r1
   task automatic build_arith();
      prog = {};
      prog.push_back(imm_inst(OP_ADDI, 1, 0, 7));
      prog.push_back(imm_inst(OP_ADDI, 2, 1, -3));
      prog.push_back(rr_inst(OP_ADD, 3, 1, 2));
      prog.push_back(rr_inst(OP_SUB, 4, 2, 3));
      prog.push_back(rr_inst(OP_AND, 5, 4, 3));
      prog.push_back(rr_inst(OP_XOR, 6, 5, 4));
      prog.push_back(rr_inst(OP_ADD, 7, 6, 6));
      for (int r = 7; r >= 1; r--) begin
         prog.push_back(imm_inst(OP_ST, r, 0, r));
      end
      prog.push_back(rr_inst(OP_HALT, 0, 0, 0));
   endtask

   task automatic build_load_use();
      prog = {};
      prog.push_back(imm_inst(OP_LD, 1, 0, 10));
      prog.push_back(rr_inst(OP_ADD, 2, 1, 1));
      prog.push_back(imm_inst(OP_ST, 2, 0, 11));
      prog.push_back(imm_inst(OP_LD, 3, 0, 12));
      prog.push_back(imm_inst(OP_ST, 3, 0, 13));
      prog.push_back(imm_inst(OP_LD, 4, 0, 14));
      prog.push_back(imm_inst(OP_ADDI, 5, 4, 1));
      prog.push_back(imm_inst(OP_ST, 5, 0, 15));
      prog.push_back(rr_inst(OP_HALT, 0, 0, 0));
   endtask

   // countdown from 5, the jump skips the store at 7
   task automatic build_loop();
      prog = {};
      prog.push_back(imm_inst(OP_ADDI, 1, 0, 5));
      prog.push_back(imm_inst(OP_ADDI, 2, 0, 0));
      prog.push_back(imm_inst(OP_ADDI, 2, 2, 1));
      prog.push_back(imm_inst(OP_ADDI, 1, 1, -1));
      prog.push_back(branch_inst(OP_BNEZ, 1, -3));
      prog.push_back(imm_inst(OP_ST, 2, 0, 3));
      prog.push_back(jump_inst(1));
      prog.push_back(imm_inst(OP_ST, 2, 0, 4));
      prog.push_back(imm_inst(OP_ST, 1, 0, 5));
      prog.push_back(rr_inst(OP_HALT, 0, 0, 0));
   endtask

   task automatic build_program(input int which);
      case (which)
         0:       build_arith();
         1:       build_load_use();
         default: build_loop();
      endcase
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic test_arith();
      logic [15:0] e [8];
      build_arith();
      run_program(1'b0, 1'b0);
      e[1] = 16'd7;
      e[2] = e[1] + 16'hfffd;
      e[3] = e[1] + e[2];
      e[4] = e[2] - e[3];
      e[5] = e[4] & e[3];
      e[6] = e[5] ^ e[4];
      e[7] = e[6] + e[6];
      for (int r = 1; r <= 7; r++) begin
         check_equal($sformatf("arith store of r%0d", r), u_mem.ram[r], e[r]);
      end
      check_equal("arith store count", 16'(u_mem.n_writes), 16'd7);
   endtask

   task automatic test_load_use();
      build_load_use();
      run_program(1'b0, 1'b0);
      check_equal("load then add", u_mem.ram[11], fill_word(10) + fill_word(10));
      check_equal("load then store", u_mem.ram[13], fill_word(12));
      check_equal("load then addi", u_mem.ram[15], fill_word(14) + 16'd1);
      check_equal("load count", 16'(u_mem.n_reads), 16'd3);
      check_equal("load-use store count", 16'(u_mem.n_writes), 16'd3);
   endtask

   task automatic test_loop();
      logic [15:0] count;
      logic [15:0] ctr;
      build_loop();
      run_program(1'b0, 1'b0);
      count = '0;
      ctr   = 16'd5;
      do begin
         count = count + 16'd1;
         ctr   = ctr - 16'd1;
      end while (ctr != 0);
      check_equal("loop iteration count", u_mem.ram[3], count);
      check_equal("word skipped by jump", u_mem.ram[4], fill_word(4));
      check_equal("final counter", u_mem.ram[5], ctr);
      check_equal("loop store count", 16'(u_mem.n_writes), 16'd2);
   endtask

   // zero-wait run against random wait states, word by word
   task automatic test_ack_delay();
      int writes;
      int reads;
      for (int p = 0; p < 3; p++) begin
         build_program(p);
         run_program(1'b0, 1'b0);
         writes = u_mem.n_writes;
         reads  = u_mem.n_reads;
         for (int a = 0; a < 256; a++) begin
            snap[a] = u_mem.ram[a];
         end
         run_program(1'b1, 1'b0);
         for (int a = 0; a < 256; a++) begin
            check_equal($sformatf("program %0d word %0d with random ack", p, a),
                        u_mem.ram[a], snap[a]);
         end
         check_equal("store count with random ack", 16'(u_mem.n_writes), 16'(writes));
         check_equal("load count with random ack", 16'(u_mem.n_reads), 16'(reads));
      end
   endtask

   task automatic test_illegal();
      prog = {};
      prog.push_back(imm_inst(OP_ADDI, 1, 0, 3));
      prog.push_back(16'hf800);
      prog.push_back(imm_inst(OP_ST, 1, 0, 2));
      prog.push_back(rr_inst(OP_HALT, 0, 0, 0));
      run_program(1'b0, 1'b1);
      check_equal("store after illegal opcode", u_mem.ram[2], 16'd3);
      check_equal("err_o still set", err, 1'b1);
   endtask

   initial begin
      rst_n    = 1'b0;
      rand_ack = 1'b0;
      test_arith();
      test_load_use();
      test_loop();
      test_ack_delay();
      test_illegal();
      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/tb_pipe16_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipe16_mem (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        rand_ack_i,
   // instruction port, combinational read
   input  logic [15:0] iaddr_i,
   output logic [15:0] inst_o,
   // wishbone slave
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic        we_i,
   input  logic [15:0] adr_i,
   input  logic [15:0] dat_i,
   output logic [15:0] dat_o,
   output logic        ack_o
);

   logic [15:0] rom [256];
   logic [15:0] ram [256];
   logic [1:0]  delay_tab [256];
   logic [1:0]  wait_cnt;
   logic [1:0]  delay;
   int unsigned seed;
   int          n_writes;
   int          n_reads;

   // one wait-state count per transfer, drawn up front
   initial begin
      ack_o        = 1'b0;
      dat_o        = '0;
      seed         = 32'h46cfa6a2;
      delay_tab[0] = 2'($urandom(seed) % 4);
      for (int i = 1; i < 256; i++) begin
         delay_tab[i] = 2'($urandom % 4);
      end
   end

   assign inst_o = rom[iaddr_i[7:0]];
   assign delay  = rand_ack_i ? delay_tab[8'(n_writes + n_reads)] : 2'd0;

   // registered ack, one pulse per transfer
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ack_o    <= 1'b0;
         dat_o    <= '0;
         wait_cnt <= '0;
         n_writes <= 0;
         n_reads  <= 0;
      end else begin
         ack_o <= 1'b0;
         if (cyc_i && stb_i && !ack_o) begin
            if (wait_cnt == delay) begin
               ack_o    <= 1'b1;
               wait_cnt <= '0;
               if (we_i) begin
                  ram[adr_i[7:0]] <= dat_i;
                  n_writes        <= n_writes + 1;
               end else begin
                  dat_o   <= ram[adr_i[7:0]];
                  n_reads <= n_reads + 1;
               end
            end else begin
               wait_cnt <= wait_cnt + 2'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: source/pipe16_proc.sv
`timescale 1ns/1ps
`default_nettype none

module pipe16_proc
   import pipe16_pkg::*;
(
   input  logic            clk,
   input  logic            rst_n,
   // instruction port
   output logic [XLEN-1:0] iaddr_o,
   input  logic [XLEN-1:0] inst_i,
   // wishbone data port
   output logic            cyc_o,
   output logic            stb_o,
   output logic            we_o,
   output logic [XLEN-1:0] adr_o,
   output logic [XLEN-1:0] dat_o,
   input  logic [XLEN-1:0] dat_i,
   input  logic            ack_i,
   // status
   output logic            err_o,
   output logic            halt_o
);

   if_id_t          if_id_d;
   if_id_t          if_id_q;
   id_ex_t          id_ex_d;
   id_ex_t          id_ex_q;
   ex_mem_t         ex_mem_d;
   ex_mem_t         ex_mem_q;
   mem_wb_t         mem_wb_d;
   mem_wb_t         mem_wb_q;

   logic [XLEN-1:0] pc_inc;
   logic            stall;
   logic            mem_busy;
   logic            taken;
   logic            redirect;
   logic            halt_pending;
   logic [XLEN-1:0] target;
   ctrl_t           ctrl_id;
   logic            illegal;
   logic [XLEN-1:0] imm_id;
   logic [1:0]      fwd_a;
   logic [1:0]      fwd_b;
   logic [XLEN-1:0] op_a;
   logic [XLEN-1:0] op_b;
   logic [XLEN-1:0] alu_res;
   logic [XLEN-1:0] ld_data;
   logic [XLEN-1:0] wb_data;
   logic            err_q;
   logic            halt_q;

   pipe16_rf_if rf_bus ();

   function automatic logic [XLEN-1:0] fwd_mux(input logic [1:0]      sel,
                                                input logic [XLEN-1:0] rf_val);
      logic [XLEN-1:0] val;
      case (sel)
         FWD_MEM: val = ex_mem_q.alu_res;
         FWD_WB:  val = wb_data;
         default: val = rf_val;
      endcase
      return val;
   endfunction

   ////////////////////////////////////////////////////////////////////////
   // fetch
   ////////////////////////////////////////////////////////////////////////

   // any halt in flight stops fetch; nothing younger may enter
   assign halt_pending = ctrl_id.halt | id_ex_q.ctrl.halt | ex_mem_q.halt
                       | mem_wb_q.halt | halt_q;

   // a frozen pipeline keeps the branch in execute until the bus is done
   assign redirect = taken & ~mem_busy;

   pipe16_fetch u_fetch (
      .clk        (clk),
      .rst_n      (rst_n),
      .hold_i     (stall | mem_busy | halt_pending),
      .redirect_i (redirect),
      .target_i   (target),
      .pc_o       (iaddr_o),
      .pc_inc_o   (pc_inc)
   );

   always_comb begin
      if_id_d.pc_inc = pc_inc;
      if_id_d.inst   = halt_pending ? NOP_INST : inst_i;
   end

   pipe16_stage_reg #(.T(if_id_t)) u_if_id (
      .clk      (clk),
      .rst_n    (rst_n),
      .hold_i   (stall | mem_busy),
      .bubble_i (redirect),
      .d_i      (if_id_d),
      .q_o      (if_id_q)
   );

   ////////////////////////////////////////////////////////////////////////
   // decode
   ////////////////////////////////////////////////////////////////////////

   pipe16_control u_control (
      .inst_i    (if_id_q.inst),
      .ctrl_o    (ctrl_id),
      .illegal_o (illegal)
   );

   assign rf_bus.raddr1 = if_id_q.inst[10:8];
   assign rf_bus.raddr2 = if_id_q.inst[7:5];

   pipe16_regfile u_regfile (
      .clk   (clk),
      .rst_n (rst_n),
      .rf    (rf_bus.rf)
   );

   // imm width follows the instruction format
   always_comb begin
      case (ctrl_id.branch)
         BR_JUMP:          imm_id = {{5{if_id_q.inst[10]}}, if_id_q.inst[10:0]};
         BR_BEQZ, BR_BNEZ: imm_id = {{8{if_id_q.inst[7]}}, if_id_q.inst[7:0]};
         default:          imm_id = {{11{if_id_q.inst[4]}}, if_id_q.inst[4:0]};
      endcase
   end

   always_comb begin
      id_ex_d.ctrl   = ctrl_id;
      id_ex_d.pc_inc = if_id_q.pc_inc;
      id_ex_d.op_a   = rf_bus.rdata1;
      id_ex_d.op_b   = rf_bus.rdata2;
      id_ex_d.imm    = imm_id;
      id_ex_d.rs     = if_id_q.inst[10:8];
      id_ex_d.rt     = if_id_q.inst[7:5];
      id_ex_d.dest   = ctrl_id.dest_rt ? if_id_q.inst[7:5] : if_id_q.inst[4:2];
   end

   pipe16_stage_reg #(.T(id_ex_t)) u_id_ex (
      .clk      (clk),
      .rst_n    (rst_n),
      .hold_i   (mem_busy),
      .bubble_i (stall | redirect),
      .d_i      (id_ex_d),
      .q_o      (id_ex_q)
   );

   ////////////////////////////////////////////////////////////////////////
   // execute
   ////////////////////////////////////////////////////////////////////////

   pipe16_hazard u_hazard (
      .id_rs_i    (if_id_q.inst[10:8]),
      .id_rt_i    (if_id_q.inst[7:5]),
      .ex_dest_i  (id_ex_q.dest),
      .ex_load_i  (id_ex_q.ctrl.mem_read),
      .mem_dest_i (ex_mem_q.dest),
      .mem_regw_i (ex_mem_q.reg_write),
      .wb_dest_i  (mem_wb_q.dest),
      .wb_regw_i  (mem_wb_q.reg_write),
      .ex_rs_i    (id_ex_q.rs),
      .ex_rt_i    (id_ex_q.rt),
      .stall_o    (stall),
      .fwd_a_o    (fwd_a),
      .fwd_b_o    (fwd_b)
   );

   always_comb begin
      op_a = fwd_mux(fwd_a, id_ex_q.op_a);
      op_b = fwd_mux(fwd_b, id_ex_q.op_b);
   end

   pipe16_alu u_alu (
      .op_i     (id_ex_q.ctrl.alu_op),
      .a_i      (op_a),
      .b_i      (id_ex_q.ctrl.alu_src_imm ? id_ex_q.imm : op_b),
      .branch_i (id_ex_q.ctrl.branch),
      .pc_inc_i (id_ex_q.pc_inc),
      .imm_i    (id_ex_q.imm),
      .result_o (alu_res),
      .taken_o  (taken),
      .target_o (target)
   );

   always_comb begin
      ex_mem_d.reg_write = id_ex_q.ctrl.reg_write;
      ex_mem_d.mem_read  = id_ex_q.ctrl.mem_read;
      ex_mem_d.mem_write = id_ex_q.ctrl.mem_write;
      ex_mem_d.halt      = id_ex_q.ctrl.halt;
      ex_mem_d.alu_res   = alu_res;
      ex_mem_d.st_data   = op_b;
      ex_mem_d.dest      = id_ex_q.dest;
   end

   pipe16_stage_reg #(.T(ex_mem_t)) u_ex_mem (
      .clk      (clk),
      .rst_n    (rst_n),
      .hold_i   (mem_busy),
      .bubble_i (1'b0),
      .d_i      (ex_mem_d),
      .q_o      (ex_mem_q)
   );

   ////////////////////////////////////////////////////////////////////////
   // memory
   ////////////////////////////////////////////////////////////////////////

   pipe16_lsu u_lsu (
      .clk     (clk),
      .rst_n   (rst_n),
      .req_i   (ex_mem_q.mem_read | ex_mem_q.mem_write),
      .write_i (ex_mem_q.mem_write),
      .addr_i  (ex_mem_q.alu_res),
      .wdata_i (ex_mem_q.st_data),
      .busy_o  (mem_busy),
      .rdata_o (ld_data),
      .cyc_o   (cyc_o),
      .stb_o   (stb_o),
      .we_o    (we_o),
      .adr_o   (adr_o),
      .dat_o   (dat_o),
      .dat_i   (dat_i),
      .ack_i   (ack_i)
   );

   always_comb begin
      mem_wb_d.reg_write  = ex_mem_q.reg_write;
      mem_wb_d.mem_to_reg = ex_mem_q.mem_read;
      mem_wb_d.halt       = ex_mem_q.halt;
      mem_wb_d.alu_res    = ex_mem_q.alu_res;
      mem_wb_d.ld_data    = ld_data;
      mem_wb_d.dest       = ex_mem_q.dest;
   end

   pipe16_stage_reg #(.T(mem_wb_t)) u_mem_wb (
      .clk      (clk),
      .rst_n    (rst_n),
      .hold_i   (mem_busy),
      .bubble_i (1'b0),
      .d_i      (mem_wb_d),
      .q_o      (mem_wb_q)
   );

   ////////////////////////////////////////////////////////////////////////
   // writeback and status
   ////////////////////////////////////////////////////////////////////////

   assign wb_data      = mem_wb_q.mem_to_reg ? mem_wb_q.ld_data : mem_wb_q.alu_res;
   assign rf_bus.we    = mem_wb_q.reg_write;
   assign rf_bus.waddr = mem_wb_q.dest;
   assign rf_bus.wdata = wb_data;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         err_q  <= 1'b0;
         halt_q <= 1'b0;
      end else begin
         err_q  <= err_q | illegal;
         halt_q <= halt_q | mem_wb_q.halt;
      end
   end

   assign err_o  = err_q;
   assign halt_o = halt_q | mem_wb_q.halt;

   // load data is not ready in MEM; the stall in decode must have kept any
   // real consumer back, so only a bubble may sit behind a load
   a_no_fwd_from_load: assert property (@(posedge clk) disable iff (!rst_n)
      ex_mem_q.mem_read && id_ex_q.ctrl != '0 |-> fwd_a != FWD_MEM && fwd_b != FWD_MEM);

endmodule

`default_nettype wire

// File: source/pipe16_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module pipe16_lsu
   import pipe16_pkg::*;
(
   input  logic            clk,
   input  logic            rst_n,
   input  logic            req_i,
   input  logic            write_i,
   input  logic [XLEN-1:0] addr_i,
   input  logic [XLEN-1:0] wdata_i,
   output logic            busy_o,
   output logic [XLEN-1:0] rdata_o,
   // wishbone master
   output logic            cyc_o,
   output logic            stb_o,
   output logic            we_o,
   output logic [XLEN-1:0] adr_o,
   output logic [XLEN-1:0] dat_o,
   input  logic [XLEN-1:0] dat_i,
   input  logic            ack_i
);

   typedef enum logic {
      LSU_IDLE,
      LSU_DONE
   } lsu_state_e;

   lsu_state_e state;

   // cycle is open from the first MEM cycle until ack; DONE releases the
   // pipeline for one cycle so the same request is not issued twice
   assign busy_o = req_i && (state == LSU_IDLE);
   assign cyc_o  = busy_o;
   assign stb_o  = busy_o;
   assign we_o   = busy_o && write_i;
   assign adr_o  = addr_i;
   assign dat_o  = wdata_i;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= LSU_IDLE;
      end else begin
         case (state)
            LSU_IDLE: begin
               if (busy_o && ack_i) begin
                  state <= LSU_DONE;
               end
            end
            default: begin
               state <= LSU_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (busy_o && ack_i && !write_i) begin
         rdata_o <= dat_i;
      end
   end

   a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
      stb_o && !ack_i |=> $stable(adr_o));

endmodule

`default_nettype wire

// File: source/pipe16_hazard.sv
`timescale 1ns/1ps
`default_nettype none

module pipe16_hazard
   import pipe16_pkg::*;
(
   input  logic [RADDR_W-1:0] id_rs_i,
   input  logic [RADDR_W-1:0] id_rt_i,
   input  logic [RADDR_W-1:0] ex_dest_i,
   input  logic               ex_load_i,
   input  logic [RADDR_W-1:0] mem_dest_i,
   input  logic               mem_regw_i,
   input  logic [RADDR_W-1:0] wb_dest_i,
   input  logic               wb_regw_i,
   input  logic [RADDR_W-1:0] ex_rs_i,
   input  logic [RADDR_W-1:0] ex_rt_i,
   output logic               stall_o,
   output logic [1:0]         fwd_a_o,
   output logic [1:0]         fwd_b_o
);

   // youngest producer wins
   function automatic logic [1:0] fwd_sel(input logic [RADDR_W-1:0] src);
      logic [1:0] sel;
      sel = FWD_REG;
      if (mem_regw_i && mem_dest_i == src) begin
         sel = FWD_MEM;
      end else if (wb_regw_i && wb_dest_i == src) begin
         sel = FWD_WB;
      end
      return sel;
   endfunction

   // both fields are checked even when the consumer reads only one
   assign stall_o = ex_load_i && (ex_dest_i == id_rs_i || ex_dest_i == id_rt_i);

   always_comb begin
      fwd_a_o = fwd_sel(ex_rs_i);
      fwd_b_o = fwd_sel(ex_rt_i);
   end

endmodule

`default_nettype wire

// File: source/pipe16_alu.sv
`timescale 1ns/1ps
`default_nettype none

module pipe16_alu
   import pipe16_pkg::*;
(
   input  alu_op_e         op_i,
   input  logic [XLEN-1:0] a_i,
   input  logic [XLEN-1:0] b_i,
   input  br_e             branch_i,
   input  logic [XLEN-1:0] pc_inc_i,
   input  logic [XLEN-1:0] imm_i,
   output logic [XLEN-1:0] result_o,
   output logic            taken_o,
   output logic [XLEN-1:0] target_o
);

   always_comb begin
      case (op_i)
         ALU_ADD: result_o = a_i + b_i;
         ALU_SUB: result_o = a_i - b_i;
         ALU_AND: result_o = a_i & b_i;
         default: result_o = a_i ^ b_i;
      endcase
   end

   // conditional branches test Rs against zero
   always_comb begin
      case (branch_i)
         BR_BEQZ: taken_o = (a_i == '0);
         BR_BNEZ: taken_o = (a_i != '0);
         BR_JUMP: taken_o = 1'b1;
         default: taken_o = 1'b0;
      endcase
   end

   // pc-relative from the next instruction
   assign target_o = pc_inc_i + imm_i;

endmodule

`default_nettype wire

// File: source/pipe16_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module pipe16_regfile
   import pipe16_pkg::*;
(
   input logic     clk,
   input logic     rst_n,
   pipe16_rf_if.rf rf
);

   logic [XLEN-1:0] regs [NREG];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NREG; i++) begin
            regs[i] <= '0;
         end
      end else if (rf.we) begin
         regs[rf.waddr] <= rf.wdata;
      end
   end

   // writeback in the same cycle as decode reads the new value
   assign rf.rdata1 = (rf.we && rf.waddr == rf.raddr1) ? rf.wdata : regs[rf.raddr1];
   assign rf.rdata2 = (rf.we && rf.waddr == rf.raddr2) ? rf.wdata : regs[rf.raddr2];

   a_waddr_known: assert property (@(posedge clk) disable iff (!rst_n)
      rf.we |-> !$isunknown(rf.waddr));

endmodule

`default_nettype wire

// File: source/pipe16_control.sv
`timescale 1ns/1ps
`default_nettype none

module pipe16_control
   import pipe16_pkg::*;
(
   input  logic [XLEN-1:0] inst_i,
   output ctrl_t           ctrl_o,
   output logic            illegal_o
);

   opcode_e opcode;

   assign opcode = opcode_e'(inst_i[15:11]);

   always_comb begin
      ctrl_o    = '0;
      illegal_o = 1'b0;
      case (opcode)
         OP_NOP: begin
            ctrl_o = '0;
         end
         OP_HALT: begin
            ctrl_o.halt = 1'b1;
         end
         // register-register, result to Rd
         OP_ADD: begin
            ctrl_o.reg_write = 1'b1;
            ctrl_o.alu_op    = ALU_ADD;
         end
         OP_SUB: begin
            ctrl_o.reg_write = 1'b1;
            ctrl_o.alu_op    = ALU_SUB;
         end
         OP_AND: begin
            ctrl_o.reg_write = 1'b1;
            ctrl_o.alu_op    = ALU_AND;
         end
         OP_XOR: begin
            ctrl_o.reg_write = 1'b1;
            ctrl_o.alu_op    = ALU_XOR;
         end
         // immediate forms write Rt
         OP_ADDI: begin
            ctrl_o.reg_write   = 1'b1;
            ctrl_o.alu_src_imm = 1'b1;
            ctrl_o.dest_rt     = 1'b1;
         end
         OP_LD: begin
            ctrl_o.reg_write   = 1'b1;
            ctrl_o.mem_read    = 1'b1;
            ctrl_o.alu_src_imm = 1'b1;
            ctrl_o.dest_rt     = 1'b1;
         end
         OP_ST: begin
            ctrl_o.mem_write   = 1'b1;
            ctrl_o.alu_src_imm = 1'b1;
         end
         OP_BEQZ: begin
            ctrl_o.branch = BR_BEQZ;
         end
         OP_BNEZ: begin
            ctrl_o.branch = BR_BNEZ;
         end
         OP_J: begin
            ctrl_o.branch = BR_JUMP;
         end
         default: begin
            illegal_o = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: source/pipe16_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module pipe16_fetch
   import pipe16_pkg::*;
(
   input  logic            clk,
   input  logic            rst_n,
   input  logic            hold_i,
   input  logic            redirect_i,
   input  logic [XLEN-1:0] target_i,
   output logic [XLEN-1:0] pc_o,
   output logic [XLEN-1:0] pc_inc_o
);

   // word addressed, one instruction per address
   assign pc_inc_o = pc_o + XLEN'(1);

   // a taken branch overrides any hold
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_o <= '0;
      end else if (redirect_i) begin
         pc_o <= target_i;
      end else if (!hold_i) begin
         pc_o <= pc_inc_o;
      end
   end

endmodule

`default_nettype wire

// File: source/pipe16_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe16_stage_reg #(
   parameter type T = logic [15:0]
) (
   input  logic clk,
   input  logic rst_n,
   input  logic hold_i,
   input  logic bubble_i,
   input  T     d_i,
   output T     q_o
);

   // all-zero payload decodes as a NOP with no control bits set
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         q_o <= '0;
      end else if (!hold_i) begin
         if (bubble_i) begin
            q_o <= '0;
         end else begin
            q_o <= d_i;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/pipe16_rf_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pipe16_rf_if
   import pipe16_pkg::*;
();

   logic [RADDR_W-1:0] raddr1;
   logic [RADDR_W-1:0] raddr2;
   logic [XLEN-1:0]    rdata1;
   logic [XLEN-1:0]    rdata2;
   logic               we;
   logic [RADDR_W-1:0] waddr;
   logic [XLEN-1:0]    wdata;

   modport core (output raddr1, raddr2, we, waddr, wdata, input rdata1, rdata2);
   modport rf (input raddr1, raddr2, we, waddr, wdata, output rdata1, rdata2);

endinterface

`default_nettype wire

// File: source/pipe16_pkg.sv
`default_nettype none

package pipe16_pkg;

   localparam int XLEN    = 16;
   localparam int NREG    = 8;
   localparam int RADDR_W = 3;

   // execute operand sources
   localparam logic [1:0] FWD_REG = 2'd0;
   localparam logic [1:0] FWD_WB  = 2'd1;
   localparam logic [1:0] FWD_MEM = 2'd2;

   // opcode lives in inst[15:11]
   typedef enum logic [4:0] {
      OP_NOP  = 5'b00000,
      OP_HALT = 5'b00001,
      OP_ADD  = 5'b00010,
      OP_SUB  = 5'b00011,
      OP_AND  = 5'b00100,
      OP_XOR  = 5'b00101,
      OP_ADDI = 5'b00110,
      OP_LD   = 5'b00111,
      OP_ST   = 5'b01000,
      OP_BEQZ = 5'b01001,
      OP_BNEZ = 5'b01010,
      OP_J    = 5'b01011
   } opcode_e;

   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR
   } alu_op_e;

   typedef enum logic [1:0] {
      BR_NONE,
      BR_BEQZ,
      BR_BNEZ,
      BR_JUMP
   } br_e;

   typedef struct packed {
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    alu_src_imm;
      alu_op_e alu_op;
      br_e     branch;
      logic    halt;
      logic    dest_rt;    // write Rt instead of Rd
   } ctrl_t;

   typedef struct packed {
      logic [XLEN-1:0] pc_inc;
      logic [XLEN-1:0] inst;
   } if_id_t;

   typedef struct packed {
      ctrl_t              ctrl;
      logic [XLEN-1:0]    pc_inc;
      logic [XLEN-1:0]    op_a;
      logic [XLEN-1:0]    op_b;
      logic [XLEN-1:0]    imm;
      logic [RADDR_W-1:0] rs;
      logic [RADDR_W-1:0] rt;
      logic [RADDR_W-1:0] dest;
   } id_ex_t;

   typedef struct packed {
      logic               reg_write;
      logic               mem_read;
      logic               mem_write;
      logic               halt;
      logic [XLEN-1:0]    alu_res;
      logic [XLEN-1:0]    st_data;
      logic [RADDR_W-1:0] dest;
   } ex_mem_t;

   typedef struct packed {
      logic               reg_write;
      logic               mem_to_reg;
      logic               halt;
      logic [XLEN-1:0]    alu_res;
      logic [XLEN-1:0]    ld_data;
      logic [RADDR_W-1:0] dest;
   } mem_wb_t;

   localparam logic [XLEN-1:0] NOP_INST = '0;

endpackage

`default_nettype wire
